// ==== hdl/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

  localparam int dmem_words = 64;

  // alu function select
  localparam logic [2:0] alu_add = 3'd0;
  localparam logic [2:0] alu_sub = 3'd1;
  localparam logic [2:0] alu_slt = 3'd2;
  localparam logic [2:0] alu_xor = 3'd3;
  localparam logic [2:0] alu_or  = 3'd4;
  localparam logic [2:0] alu_and = 3'd5;

  localparam logic [2:0] mem_none = 3'd0;
  localparam logic [2:0] mem_lb   = 3'd1;
  localparam logic [2:0] mem_lbu  = 3'd2;
  localparam logic [2:0] mem_lw   = 3'd3;
  localparam logic [2:0] mem_sb   = 3'd4;
  localparam logic [2:0] mem_sw   = 3'd5;

  localparam logic [1:0] br_none = 2'd0;
  localparam logic [1:0] br_eq   = 2'd1;
  localparam logic [1:0] br_ne   = 2'd2;
  localparam logic [1:0] br_jal  = 2'd3;

  // major opcodes
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  // execute unit states
  localparam logic [1:0] ex_idle = 2'd0;
  localparam logic [1:0] ex_hold = 2'd1;
  localparam logic [1:0] ex_req  = 2'd2;
  localparam logic [1:0] ex_rsp  = 2'd3;

  // pc, op_a, op_b, store data, imm, rd, alu_fn, use_imm, mem_op, br_op
  localparam int uop_width = 5 * 32 + 5 + 3 + 1 + 3 + 2;

  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    // S and B share this split, B scrambles the bits
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } sb;
  } rv_instr_u;

endpackage

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

module alu import rv_exec_pkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [2:0]  fn,
  output logic [31:0] result
);

  logic less;

  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (fn)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_slt: result = {31'd0, less};
      alu_xor: result = a ^ b;
      alu_or:  result = a | b;
      alu_and: result = a & b;
      default: result = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`default_nettype none

module instr_decoder import rv_exec_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        issue_valid,
  output logic        issue_ready,
  input  rv_instr_u   issue_instr,
  input  logic [31:0] issue_pc,
  input  logic [31:0] issue_rs1_value,
  input  logic [31:0] issue_rs2_value,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [31:0] out_pc,
  output logic [31:0] out_op_a,
  output logic [31:0] out_op_b,
  output logic [31:0] out_store_data,
  output logic [31:0] out_imm,
  output logic [4:0]  out_rd,
  output logic [2:0]  out_alu_fn,
  output logic        out_use_imm,
  output logic [2:0]  out_mem_op,
  output logic [1:0]  out_br_op
);

  logic        active;
  logic        legal;
  logic [31:0] imm;
  logic [4:0]  rd;
  logic [2:0]  alu_fn;
  logic        use_imm;
  logic [2:0]  mem_op;
  logic [1:0]  br_op;

  assign issue_ready = active & (~out_valid | out_ready);

  always_comb begin
    imm     = {{20{issue_instr.i.imm[11]}}, issue_instr.i.imm};
    rd      = issue_instr.i.rd;
    alu_fn  = alu_add;
    use_imm = 1'b0;
    mem_op  = mem_none;
    br_op   = br_none;
    legal   = 1'b1;
    case (issue_instr.i.opcode)
      op_imm: begin
        use_imm = 1'b1;
        case (issue_instr.i.funct3)
          3'b000:  alu_fn = alu_add;
          3'b010:  alu_fn = alu_slt;
          3'b100:  alu_fn = alu_xor;
          3'b110:  alu_fn = alu_or;
          3'b111:  alu_fn = alu_and;
          default: legal = 1'b0;
        endcase
      end
      op_reg: begin
        case (issue_instr.i.funct3)
          // funct7 bit 5 picks sub
          3'b000:  alu_fn = issue_instr.i.imm[10] ? alu_sub : alu_add;
          3'b010:  alu_fn = alu_slt;
          3'b100:  alu_fn = alu_xor;
          3'b110:  alu_fn = alu_or;
          3'b111:  alu_fn = alu_and;
          default: legal = 1'b0;
        endcase
      end
      op_load: begin
        use_imm = 1'b1;
        case (issue_instr.i.funct3)
          3'b000:  mem_op = mem_lb;
          3'b100:  mem_op = mem_lbu;
          3'b010:  mem_op = mem_lw;
          default: legal = 1'b0;
        endcase
      end
      op_store: begin
        use_imm = 1'b1;
        rd      = 5'd0;
        imm     = {{20{issue_instr.sb.imm_hi[6]}}, issue_instr.sb.imm_hi, issue_instr.sb.imm_lo};
        case (issue_instr.sb.funct3)
          3'b000:  mem_op = mem_sb;
          3'b010:  mem_op = mem_sw;
          default: legal = 1'b0;
        endcase
      end
      op_branch: begin
        alu_fn = alu_sub;
        rd     = 5'd0;
        imm    = {{19{issue_instr.sb.imm_hi[6]}}, issue_instr.sb.imm_hi[6],
                  issue_instr.sb.imm_lo[0], issue_instr.sb.imm_hi[5:0],
                  issue_instr.sb.imm_lo[4:1], 1'b0};
        case (issue_instr.sb.funct3)
          3'b000:  br_op = br_eq;
          3'b001:  br_op = br_ne;
          default: legal = 1'b0;
        endcase
      end
      op_jal: begin
        br_op = br_jal;
        // J immediate, bits 19:12 sit where rs1 and funct3 are
        imm   = {{12{issue_instr.i.imm[11]}}, issue_instr.i.rs1, issue_instr.i.funct3,
                 issue_instr.i.imm[0], issue_instr.i.imm[10:1], 1'b0};
      end
      default: legal = 1'b0;
    endcase
    // anything else retires as a harmless add to x0
    if (!legal) begin
      alu_fn  = alu_add;
      use_imm = 1'b0;
      mem_op  = mem_none;
      br_op   = br_none;
      rd      = 5'd0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      active    <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      active <= 1'b1;
      if (issue_valid & issue_ready) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue_valid & issue_ready) begin
      out_pc         <= issue_pc;
      out_op_a       <= issue_rs1_value;
      out_op_b       <= issue_rs2_value;
      out_store_data <= issue_rs2_value;
      out_imm        <= imm;
      out_rd         <= rd;
      out_alu_fn     <= alu_fn;
      out_use_imm    <= use_imm;
      out_mem_op     <= mem_op;
      out_br_op      <= br_op;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/issue_buffer.sv ====
`default_nettype none

module issue_buffer import rv_exec_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [uop_width-1:0] in_uop,
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [uop_width-1:0] out_uop
);

  logic [uop_width-1:0] entries [2];
  logic                 wr_ptr;
  logic                 rd_ptr;
  logic [1:0]           count;
  logic                 push;
  logic                 pop;

  // full buffer still takes a push when the head leaves
  assign in_ready  = (count != 2'd2) | out_ready;
  assign out_valid = count != 2'd0;
  assign out_uop   = entries[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      entries[wr_ptr] <= in_uop;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/execute_unit.sv ====
`default_nettype none

module execute_unit import rv_exec_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [uop_width-1:0] in_uop,
  output logic                 req_valid,
  output logic                 req_write,
  input  logic                 req_ready,
  output logic [31:0]          req_addr,
  output logic [31:0]          req_wdata,
  output logic [3:0]           req_strb,
  input  logic                 rsp_valid,
  output logic                 rsp_ready,
  input  logic [31:0]          rsp_rdata,
  output logic                 wb_valid,
  input  logic                 wb_ready,
  output logic                 wb_wen,
  output logic [4:0]           wb_rd,
  output logic [31:0]          wb_data,
  output logic                 redirect,
  output logic [31:0]          redirect_pc
);

  logic [1:0]           state;
  logic [1:0]           state_next;
  logic [uop_width-1:0] uop;
  logic [uop_width-1:0] uop_next;
  logic [31:0]          load_val;
  logic [31:0]          load_val_next;

  logic [31:0] pc;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] store_data;
  logic [31:0] imm;
  logic [4:0]  rd;
  logic [2:0]  alu_fn;
  logic        use_imm;
  logic [2:0]  mem_op;
  logic [1:0]  br_op;
  logic [2:0]  in_mem_op;

  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic [7:0]  byte_sel;
  logic [31:0] rdata_lane;
  logic [3:0]  strb_base;
  logic        is_store;
  logic        is_load;
  logic        is_branch;
  logic        taken;

  assign {pc, op_a, op_b, store_data, imm, rd, alu_fn, use_imm, mem_op, br_op} = uop;
  assign in_mem_op = in_uop[4:2];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ex_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    uop      <= uop_next;
    load_val <= load_val_next;
  end

  assign in_ready = (state == ex_idle) | ((state == ex_hold) & wb_ready);

  always_comb begin
    state_next    = state;
    uop_next      = uop;
    load_val_next = load_val;
    case (state)
      ex_hold: begin
        if (wb_ready) begin
          state_next = ex_idle;
        end
      end
      ex_req: begin
        if (req_ready) begin
          state_next = ex_rsp;
        end
      end
      ex_rsp: begin
        if (rsp_valid) begin
          load_val_next = rdata_lane;
          state_next    = ex_hold;
        end
      end
      default: ;
    endcase
    // new micro-op overrides the drop back to idle
    if (in_valid & in_ready) begin
      uop_next   = in_uop;
      state_next = (in_mem_op == mem_none) ? ex_hold : ex_req;
    end
  end

  assign alu_b = use_imm ? imm : op_b;

  alu alu_inst (
    .a      (op_a),
    .b      (alu_b),
    .fn     (alu_fn),
    .result (alu_result)
  );

  // memory side, address comes from the alu
  assign is_store  = (mem_op == mem_sb) | (mem_op == mem_sw);
  assign is_load   = (mem_op != mem_none) & ~is_store;
  assign strb_base = (mem_op == mem_sw) ? 4'b1111 : ((mem_op == mem_sb) ? 4'b0001 : 4'b0000);

  assign req_valid = state == ex_req;
  assign req_write = is_store;
  assign req_addr  = alu_result;
  assign req_wdata = store_data << {alu_result[1:0], 3'b000};
  assign req_strb  = strb_base << alu_result[1:0];
  assign rsp_ready = state == ex_rsp;

  assign byte_sel = rsp_rdata[alu_result[1:0] * 8 +: 8];

  always_comb begin
    case (mem_op)
      mem_lb:  rdata_lane = {{24{byte_sel[7]}}, byte_sel};
      mem_lbu: rdata_lane = {24'd0, byte_sel};
      default: rdata_lane = rsp_rdata;
    endcase
  end

  // branches compare by subtraction
  assign is_branch = (br_op == br_eq) | (br_op == br_ne);

  always_comb begin
    case (br_op)
      br_eq:   taken = alu_result == 32'd0;
      br_ne:   taken = alu_result != 32'd0;
      br_jal:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign wb_valid    = state == ex_hold;
  assign redirect    = wb_valid & taken;
  assign redirect_pc = pc + imm;

  assign wb_wen  = (rd != 5'd0) & ~is_store & ~is_branch;
  assign wb_rd   = rd;
  assign wb_data = is_load ? load_val : ((br_op == br_jal) ? pc + 32'd4 : alu_result);

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`default_nettype none

module data_ram import rv_exec_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  input  logic        req_write,
  output logic        req_ready,
  input  logic [31:0] req_addr,
  input  logic [31:0] req_wdata,
  input  logic [3:0]  req_strb,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output logic [31:0] rsp_rdata
);

  logic [31:0]                   mem [dmem_words];
  logic [$clog2(dmem_words)-1:0] word_idx;
  logic                          req_take;

  // word index drops the byte offset
  assign word_idx  = req_addr[$clog2(dmem_words)+1:2];
  assign req_ready = ~rsp_valid | rsp_ready;
  assign req_take  = req_valid & req_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int w = 0; w < dmem_words; w++) begin
        mem[w] <= 32'd0;
      end
    end else if (req_take & req_write) begin
      for (int b = 0; b < 4; b++) begin
        if (req_strb[b]) begin
          mem[word_idx][8*b +: 8] <= req_wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else if (req_take) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // write acknowledge carries zero
  always_ff @(posedge clock) begin
    if (req_take) begin
      rsp_rdata <= req_write ? 32'd0 : mem[word_idx];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/exec_subsystem.sv ====
`default_nettype none

module exec_subsystem import rv_exec_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        issue_valid,
  output logic        issue_ready,
  input  rv_instr_u   issue_instr,
  input  logic [31:0] issue_pc,
  input  logic [31:0] issue_rs1_value,
  input  logic [31:0] issue_rs2_value,
  output logic        wb_valid,
  input  logic        wb_ready,
  output logic        wb_wen,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data,
  output logic        redirect,
  output logic [31:0] redirect_pc
);

  logic                 dec_valid;
  logic                 dec_ready;
  logic [31:0]          dec_pc;
  logic [31:0]          dec_op_a;
  logic [31:0]          dec_op_b;
  logic [31:0]          dec_store_data;
  logic [31:0]          dec_imm;
  logic [4:0]           dec_rd;
  logic [2:0]           dec_alu_fn;
  logic                 dec_use_imm;
  logic [2:0]           dec_mem_op;
  logic [1:0]           dec_br_op;
  logic [uop_width-1:0] dec_uop;
  logic                 buf_valid;
  logic                 buf_ready;
  logic [uop_width-1:0] buf_uop;
  logic                 req_valid;
  logic                 req_write;
  logic                 req_ready;
  logic [31:0]          req_addr;
  logic [31:0]          req_wdata;
  logic [3:0]           req_strb;
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic [31:0]          rsp_rdata;

  // field order matches the unpack in execute_unit
  assign dec_uop = {dec_pc, dec_op_a, dec_op_b, dec_store_data, dec_imm, dec_rd,
                    dec_alu_fn, dec_use_imm, dec_mem_op, dec_br_op};

  instr_decoder instr_decoder_inst (
    .clock           (clock),
    .reset           (reset),
    .issue_valid     (issue_valid),
    .issue_ready     (issue_ready),
    .issue_instr     (issue_instr),
    .issue_pc        (issue_pc),
    .issue_rs1_value (issue_rs1_value),
    .issue_rs2_value (issue_rs2_value),
    .out_valid       (dec_valid),
    .out_ready       (dec_ready),
    .out_pc          (dec_pc),
    .out_op_a        (dec_op_a),
    .out_op_b        (dec_op_b),
    .out_store_data  (dec_store_data),
    .out_imm         (dec_imm),
    .out_rd          (dec_rd),
    .out_alu_fn      (dec_alu_fn),
    .out_use_imm     (dec_use_imm),
    .out_mem_op      (dec_mem_op),
    .out_br_op       (dec_br_op)
  );

  issue_buffer issue_buffer_inst (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (dec_valid),
    .in_ready  (dec_ready),
    .in_uop    (dec_uop),
    .out_valid (buf_valid),
    .out_ready (buf_ready),
    .out_uop   (buf_uop)
  );

  execute_unit execute_unit_inst (
    .clock       (clock),
    .reset       (reset),
    .in_valid    (buf_valid),
    .in_ready    (buf_ready),
    .in_uop      (buf_uop),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_ready   (req_ready),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_strb    (req_strb),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_rdata   (rsp_rdata),
    .wb_valid    (wb_valid),
    .wb_ready    (wb_ready),
    .wb_wen      (wb_wen),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  data_ram data_ram_inst (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_ready (req_ready),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_strb  (req_strb),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata)
  );

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // reset held for four rising edges
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tests/exec_subsystem_sva.sv ====
`default_nettype none

module exec_subsystem_sva import rv_exec_pkg::*; (
  input logic                 clock,
  input logic                 reset,
  input logic                 in_valid,
  input logic                 in_ready,
  input logic [uop_width-1:0] in_uop,
  input logic                 wb_valid,
  input logic                 wb_ready,
  input logic                 wb_wen,
  input logic [4:0]           wb_rd,
  input logic [31:0]          wb_data,
  input logic                 redirect,
  input logic [31:0]          redirect_pc,
  input logic                 req_valid
);

  timeunit 1ns;
  timeprecision 100ps;

  // a stalled record must not move
  assert property (@(posedge clock) disable iff (reset)
    wb_valid && !wb_ready |=> wb_valid && $stable(wb_wen) && $stable(wb_rd)
      && $stable(wb_data) && $stable(redirect) && $stable(redirect_pc))
    else $error("writeback record changed while wb_ready was low");

  // buffered micro-op waits unchanged for the execute unit
  assert property (@(posedge clock) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable(in_uop))
    else $error("issued micro-op changed while in_ready was low");

  assert property (@(posedge clock) reset |=> !req_valid)
    else $error("memory request raised right after reset");

endmodule

`default_nettype wire

// ==== tests/exec_subsystem_tb.sv ====
`default_nettype none

module exec_subsystem_tb import rv_exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic        clock;
  logic        reset;
  logic        issue_valid;
  logic        issue_ready;
  rv_instr_u   issue_instr;
  logic [31:0] issue_pc;
  logic [31:0] issue_rs1_value;
  logic [31:0] issue_rs2_value;
  logic        wb_valid;
  logic        wb_ready;
  logic        wb_wen;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        redirect;
  logic [31:0] redirect_pc;

  // stimulus table and expected results per entry
  logic [31:0] instr_tab [$];
  logic [31:0] pc_tab [$];
  logic [31:0] rs1_tab [$];
  logic [31:0] rs2_tab [$];
  logic        exp_wen [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic        exp_redir [$];
  logic [31:0] exp_target [$];
  logic [7:0]  mem_image [dmem_words * 4];

  integer seed;
  int     n_entries;
  int     n_ret;
  int     issue_stalls;
  int     cycles_out_of_reset;

  clock_gen clock_gen_inst (
    .clock (clock),
    .reset (reset)
  );

  exec_subsystem exec_subsystem_inst (
    .clock           (clock),
    .reset           (reset),
    .issue_valid     (issue_valid),
    .issue_ready     (issue_ready),
    .issue_instr     (issue_instr),
    .issue_pc        (issue_pc),
    .issue_rs1_value (issue_rs1_value),
    .issue_rs2_value (issue_rs2_value),
    .wb_valid        (wb_valid),
    .wb_ready        (wb_ready),
    .wb_wen          (wb_wen),
    .wb_rd           (wb_rd),
    .wb_data         (wb_data),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc)
  );

  bind execute_unit exec_subsystem_sva exec_subsystem_sva_inst (
    .clock       (clock),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_uop      (in_uop),
    .wb_valid    (wb_valid),
    .wb_ready    (wb_ready),
    .wb_wen      (wb_wen),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .req_valid   (req_valid)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input int k,
                                 input logic [31:0] got, input logic [31:0] want);
    abort_run($sformatf("CHECK FAILED %s entry %0d got %h expected %h", name, k, got, want));
  endtask

  function automatic rv_instr_u itype(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    rv_instr_u u;
    u.i.imm    = imm;
    u.i.rs1    = 5'd1;
    u.i.funct3 = f3;
    u.i.rd     = rd;
    u.i.opcode = opc;
    return u;
  endfunction

  // R format lines up with the S/B view with funct7 in the high field
  function automatic rv_instr_u rtype(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd);
    rv_instr_u u;
    u.sb = '{imm_hi: f7, rs2: 5'd2, rs1: 5'd1, funct3: f3, imm_lo: rd, opcode: op_reg};
    return u;
  endfunction

  function automatic rv_instr_u stype(input logic [11:0] imm, input logic [2:0] f3);
    rv_instr_u u;
    u.sb = '{imm_hi: imm[11:5], rs2: 5'd2, rs1: 5'd1, funct3: f3, imm_lo: imm[4:0],
             opcode: op_store};
    return u;
  endfunction

  function automatic rv_instr_u btype(input logic [12:0] imm, input logic [2:0] f3);
    rv_instr_u u;
    u.sb = '{imm_hi: {imm[12], imm[10:5]}, rs2: 5'd2, rs1: 5'd1, funct3: f3,
             imm_lo: {imm[4:1], imm[11]}, opcode: op_branch};
    return u;
  endfunction

  function automatic rv_instr_u jtype(input logic [20:0] imm, input logic [4:0] rd);
    rv_instr_u u;
    u.i.imm    = {imm[20], imm[10:1], imm[11]};
    u.i.rs1    = imm[19:15];
    u.i.funct3 = imm[14:12];
    u.i.rd     = rd;
    u.i.opcode = op_jal;
    return u;
  endfunction

  task automatic add_entry(input rv_instr_u instr, input logic [31:0] rs1v,
                           input logic [31:0] rs2v);
    pc_tab.push_back(32'h0000_0200 + 32'(4 * instr_tab.size()));
    instr_tab.push_back(instr);
    rs1_tab.push_back(rs1v);
    rs2_tab.push_back(rs2v);
  endtask

  function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b100:  return x ^ y;
      3'b110:  return x | y;
      3'b111:  return x & y;
      default: return 32'd0;
    endcase
  endfunction

  // reference model straight from the RV32I encoding
  task automatic predict(input int k);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] target;
    logic        wen;
    logic        redir;
    int          byte_idx;
    int          word_idx;
    w        = instr_tab[k];
    a        = rs1_tab[k];
    b        = rs2_tab[k];
    pc       = pc_tab[k];
    wen      = 1'b0;
    redir    = 1'b0;
    data     = 32'd0;
    target   = 32'd0;
    addr     = (w[6:0] == op_store) ? a + {{20{w[31]}}, w[31:25], w[11:7]}
                                    : a + {{20{w[31]}}, w[31:20]};
    byte_idx = int'(addr % (dmem_words * 4));
    word_idx = byte_idx - (byte_idx % 4);
    case (w[6:0])
      op_imm: begin
        wen  = w[11:7] != 5'd0;
        data = arith(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
      end
      op_reg: begin
        wen  = w[11:7] != 5'd0;
        data = arith(w[14:12], w[30], a, b);
      end
      op_load: begin
        wen = w[11:7] != 5'd0;
        case (w[14:12])
          3'b000:  data = {{24{mem_image[byte_idx][7]}}, mem_image[byte_idx]};
          3'b100:  data = {24'd0, mem_image[byte_idx]};
          default: data = {mem_image[word_idx + 3], mem_image[word_idx + 2],
                           mem_image[word_idx + 1], mem_image[word_idx]};
        endcase
      end
      op_store: begin
        if (w[14:12] == 3'b000) begin
          mem_image[byte_idx] = b[7:0];
        end else begin
          for (int i = 0; i < 4; i++) begin
            mem_image[word_idx + i] = b[8*i +: 8];
          end
        end
      end
      op_branch: begin
        target = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        redir  = (w[14:12] == 3'b000) ? (a == b) : (a != b);
      end
      op_jal: begin
        wen    = w[11:7] != 5'd0;
        data   = pc + 32'd4;
        redir  = 1'b1;
        target = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      default: ;
    endcase
    exp_wen.push_back(wen);
    exp_rd.push_back(w[11:7]);
    exp_data.push_back(data);
    exp_redir.push_back(redir);
    exp_target.push_back(target);
  endtask

  task automatic build_table();
    // register and immediate ALU ops plus slt with negative operands
    add_entry(rtype(7'h00, 3'b000, 5'd1), 32'd5, 32'd7);
    add_entry(rtype(7'h20, 3'b000, 5'd2), 32'd5, 32'd7);
    add_entry(rtype(7'h00, 3'b010, 5'd3), 32'hffff_fffd, 32'd2);
    add_entry(rtype(7'h00, 3'b010, 5'd3), 32'd2, 32'hffff_fffd);
    add_entry(rtype(7'h00, 3'b010, 5'd3), 32'hffff_fff0, 32'hffff_fffe);
    add_entry(rtype(7'h00, 3'b100, 5'd4), 32'hf0f0_1234, 32'h0ff0_4321);
    add_entry(rtype(7'h00, 3'b110, 5'd5), 32'h8000_0101, 32'h0000_f010);
    add_entry(rtype(7'h00, 3'b111, 5'd6), 32'hff00_ff00, 32'h0ff0_0ff0);
    add_entry(itype(12'hfff, 3'b000, 5'd7, op_imm), 32'd10, 32'd0);
    add_entry(itype(12'hffc, 3'b010, 5'd8, op_imm), 32'hffff_fffb, 32'd0);
    add_entry(itype(12'h7ff, 3'b100, 5'd9, op_imm), 32'h1234_5678, 32'd0);
    add_entry(itype(12'hff0, 3'b110, 5'd10, op_imm), 32'h0000_000f, 32'd0);
    add_entry(itype(12'h0f0, 3'b111, 5'd11, op_imm), 32'hffff_ffff, 32'd0);
    add_entry(rtype(7'h00, 3'b000, 5'd0), 32'd1, 32'd2);
    // word store and load back
    add_entry(stype(12'h004, 3'b010), 32'h20, 32'h1234_5678);
    add_entry(itype(12'h004, 3'b010, 5'd12, op_load), 32'h20, 32'd0);
    // one byte lane at a time
    add_entry(stype(12'h000, 3'b010), 32'h40, 32'h1122_3344);
    add_entry(stype(12'h000, 3'b000), 32'h40, 32'h0000_00a5);
    add_entry(itype(12'h000, 3'b010, 5'd13, op_load), 32'h40, 32'd0);
    add_entry(stype(12'h001, 3'b000), 32'h40, 32'h0000_ffb6);
    add_entry(itype(12'h000, 3'b010, 5'd13, op_load), 32'h40, 32'd0);
    add_entry(stype(12'h002, 3'b000), 32'h40, 32'h0000_00c7);
    add_entry(itype(12'h000, 3'b010, 5'd13, op_load), 32'h40, 32'd0);
    add_entry(stype(12'hffb, 3'b000), 32'h48, 32'h0000_009c);
    add_entry(itype(12'h000, 3'b010, 5'd13, op_load), 32'h40, 32'd0);
    add_entry(itype(12'h003, 3'b000, 5'd14, op_load), 32'h40, 32'd0);
    add_entry(itype(12'h003, 3'b100, 5'd15, op_load), 32'h40, 32'd0);
    // branches both ways and then jumps
    add_entry(btype(13'h0814, 3'b000), 32'd7, 32'd7);
    add_entry(btype(13'h0010, 3'b000), 32'd7, 32'd8);
    add_entry(btype(13'h1ff8, 3'b001), 32'd9, 32'd9);
    add_entry(btype(13'h1ff8, 3'b001), 32'd9, 32'd10);
    add_entry(jtype(21'h00_0800, 5'd1), 32'd0, 32'd0);
    add_entry(jtype(21'h1f_fffc, 5'd0), 32'd0, 32'd0);
    n_entries = instr_tab.size();
  endtask

  // issue side
  initial begin
    bit accepted;
    issue_valid     = 1'b0;
    issue_instr     = '0;
    issue_pc        = 32'd0;
    issue_rs1_value = 32'd0;
    issue_rs2_value = 32'd0;
    n_ret           = 0;
    issue_stalls    = 0;
    for (int i = 0; i < dmem_words * 4; i++) begin
      mem_image[i] = 8'd0;
    end
    build_table();
    for (int k = 0; k < n_entries; k++) begin
      predict(k);
    end
    @(negedge reset);
    @(posedge clock);
    #1;
    for (int k = 0; k < n_entries; k++) begin
      issue_valid     = 1'b1;
      issue_instr     = instr_tab[k];
      issue_pc        = pc_tab[k];
      issue_rs1_value = rs1_tab[k];
      issue_rs2_value = rs2_tab[k];
      do begin
        @(negedge clock);
        accepted = issue_ready;
        if (!accepted) begin
          issue_stalls++;
        end
        @(posedge clock);
        #1;
      end while (!accepted);
    end
    issue_valid = 1'b0;
    wait (n_ret == n_entries);
    repeat (2) @(posedge clock);
    if (issue_stalls == 0) begin
      abort_run("issue_ready never dropped while writeback was stalled");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

  // random wb_ready with a long stall every 24 cycles to fill the pipe
  initial begin
    int unsigned cyc;
    logic [31:0] r;
    seed     = 32'h953b_e5c0;
    cyc      = 0;
    wb_ready = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      r        = $random(seed);
      wb_ready = (cyc % 24 >= 16) ? 1'b0 : (r[0] | r[1]);
      cyc++;
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clock) begin
    int k;
    if (reset) begin
      cycles_out_of_reset = 0;
      assert (wb_valid === 1'b0 && redirect === 1'b0)
        else abort_run("wb_valid or redirect was high during reset");
    end else begin
      if (cycles_out_of_reset < 2) begin
        assert (wb_valid === 1'b0 && redirect === 1'b0)
          else abort_run("wb_valid or redirect was high right after reset");
      end
      cycles_out_of_reset++;
      if (wb_valid === 1'b1 && wb_ready === 1'b1) begin
        k = n_ret;
        assert (k < n_entries)
          else abort_run("writeback seen with no instruction left in the table");
        assert (wb_wen === exp_wen[k])
          else report_mismatch("wb_wen", k, 32'(wb_wen), 32'(exp_wen[k]));
        assert (redirect === exp_redir[k])
          else report_mismatch("redirect", k, 32'(redirect), 32'(exp_redir[k]));
        if (exp_wen[k]) begin
          assert (wb_rd === exp_rd[k])
            else report_mismatch("wb_rd", k, 32'(wb_rd), 32'(exp_rd[k]));
          assert (wb_data === exp_data[k])
            else report_mismatch("wb_data", k, wb_data, exp_data[k]);
        end
        if (exp_redir[k]) begin
          assert (redirect_pc === exp_target[k])
            else report_mismatch("redirect_pc", k, redirect_pc, exp_target[k]);
        end
        n_ret++;
      end
    end
  end

  initial begin
    wait (n_entries > 0);
    repeat (40 * n_entries + 10) @(posedge clock);
    abort_run($sformatf("writeback stream stalled with %0d of %0d entries retired",
                        n_ret, n_entries));
  end

endmodule

`default_nettype wire

// ==== exec_subsystem.f ====
hdl/rv_exec_pkg.sv
hdl/alu.sv
hdl/instr_decoder.sv
hdl/issue_buffer.sv
hdl/execute_unit.sv
hdl/data_ram.sv
hdl/exec_subsystem.sv
tests/clock_gen.sv
tests/exec_subsystem_sva.sv
tests/exec_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: exec_subsystem

sources:
  - files:
      - hdl/rv_exec_pkg.sv
      - hdl/alu.sv
      - hdl/instr_decoder.sv
      - hdl/issue_buffer.sv
      - hdl/execute_unit.sv
      - hdl/data_ram.sv
      - hdl/exec_subsystem.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/exec_subsystem_sva.sv
      - tests/exec_subsystem_tb.sv
